// ==== fft_types_pkg.sv ====
package fft_types_pkg;

	// four complex lanes per block
	localparam int n_lanes = 4;

	// input and output samples
	localparam int sample_w = 18;
	// after the first add/subtract layer
	localparam int s1_w = 19;
	// after the second add/subtract layer
	localparam int s2_w = 20;

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic signed [s1_w-1:0] s1_t;
	typedef logic signed [s2_w-1:0] s2_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	typedef struct packed {
		s1_t re;
		s1_t im;
	} cplx1_t;

	typedef struct packed {
		s2_t re;
		s2_t im;
	} cplx2_t;

	// one block of lanes at each width
	typedef cplx_t [n_lanes-1:0] blk_t;
	typedef cplx1_t [n_lanes-1:0] blk1_t;
	typedef cplx2_t [n_lanes-1:0] blk2_t;

endpackage

// ==== radix_ctrl_pkg.sv ====
package radix_ctrl_pkg;

	// zero is radix-2, one is radix-4
	typedef logic radix_sel_t;

	localparam radix_sel_t radix_2 = 1'b0;
	localparam radix_sel_t radix_4 = 1'b1;

	// headroom already present at the input
	typedef logic [1:0] margin_t;
	// right shift applied to a block
	typedef logic [1:0] growth_t;
	// block exponent
	typedef logic [3:0] exp_t;

	// worst-case bit growth of each radix
	localparam growth_t growth_r2 = 2'd2;
	localparam growth_t growth_r4 = 2'd3;

	// control that travels down the pipeline with each block
	typedef struct packed {
		logic valid;
		radix_sel_t radix;
		logic inverse;
		growth_t shift;
		exp_t exp_next;
	} pipe_ctrl_t;

endpackage

// ==== r24_input_stage.sv ====
`timescale 1ns/100ps

module r24_input_stage
	import fft_types_pkg::*;
	import radix_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_val_i,
	input blk_t din_i,
	input radix_sel_t radix_i,
	input logic inverse_i,
	input margin_t margin_i,
	input exp_t exp_i,
	output blk1_t s1_data_o,
	output pipe_ctrl_t s1_ctrl_o
);

	cplx_t pa_x;
	cplx_t pa_y;
	cplx_t pb_x;
	cplx_t pb_y;
	growth_t growth;
	growth_t shift;

	// butterfly order: (0,2),(1,3) for radix-4, (0,1),(2,3) for radix-2
	always_comb begin
		pa_x = din_i[0];
		pb_y = din_i[3];
		if (radix_i == radix_4) begin
			pa_y = din_i[2];
			pb_x = din_i[1];
		end else begin
			pa_y = din_i[1];
			pb_x = din_i[2];
		end
	end

	// worst case growth less the margin, never below zero
	assign growth = (radix_i == radix_4) ? growth_r4 : growth_r2;
	assign shift = (growth > margin_i) ? growth - margin_i : '0;

	// lane order is sum A, diff A, sum B, diff B
	always_ff @(posedge clk) begin
		s1_data_o[0].re <= s1_t'(pa_x.re) + s1_t'(pa_y.re);
		s1_data_o[0].im <= s1_t'(pa_x.im) + s1_t'(pa_y.im);
		s1_data_o[1].re <= s1_t'(pa_x.re) - s1_t'(pa_y.re);
		s1_data_o[1].im <= s1_t'(pa_x.im) - s1_t'(pa_y.im);
		s1_data_o[2].re <= s1_t'(pb_x.re) + s1_t'(pb_y.re);
		s1_data_o[2].im <= s1_t'(pb_x.im) + s1_t'(pb_y.im);
		s1_data_o[3].re <= s1_t'(pb_x.re) - s1_t'(pb_y.re);
		s1_data_o[3].im <= s1_t'(pb_x.im) - s1_t'(pb_y.im);
	end

	always_ff @(posedge clk) begin
		s1_ctrl_o.radix <= radix_i;
		s1_ctrl_o.inverse <= inverse_i;
		s1_ctrl_o.shift <= shift;
		// exponent wraps at four bits
		s1_ctrl_o.exp_next <= exp_i + exp_t'(shift);
		if (!rst_n) begin
			s1_ctrl_o.valid <= 1'b0;
		end else begin
			s1_ctrl_o.valid <= in_val_i;
		end
	end

endmodule

// ==== r24_combine_stage.sv ====
`timescale 1ns/100ps

module r24_combine_stage
	import fft_types_pkg::*;
	import radix_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input blk1_t s1_data_i,
	input pipe_ctrl_t s1_ctrl_i,
	output blk2_t s2_data_o,
	output pipe_ctrl_t s2_ctrl_o
);

	cplx2_t sa;
	cplx2_t da;
	cplx2_t sb;
	cplx2_t db;
	blk2_t s2_next;

	function automatic cplx2_t widen(input cplx1_t v);
		cplx2_t w;
		w.re = s2_t'(v.re);
		w.im = s2_t'(v.im);
		return w;
	endfunction

	assign sa = widen(s1_data_i[0]);
	assign da = widen(s1_data_i[1]);
	assign sb = widen(s1_data_i[2]);
	assign db = widen(s1_data_i[3]);

	always_comb begin
		if (s1_ctrl_i.radix == radix_4) begin
			s2_next[0].re = sa.re + sb.re;
			s2_next[0].im = sa.im + sb.im;
			s2_next[2].re = sa.re - sb.re;
			s2_next[2].im = sa.im - sb.im;
			if (!s1_ctrl_i.inverse) begin
				// X1 = dA - j*dB, X3 = dA + j*dB
				s2_next[1].re = da.re + db.im;
				s2_next[1].im = da.im - db.re;
				s2_next[3].re = da.re - db.im;
				s2_next[3].im = da.im + db.re;
			end else begin
				// inverse turns the other way
				s2_next[1].re = da.re - db.im;
				s2_next[1].im = da.im + db.re;
				s2_next[3].re = da.re + db.im;
				s2_next[3].im = da.im - db.re;
			end
		end else begin
			// two-point results are already in natural order
			s2_next[0] = sa;
			s2_next[1] = da;
			s2_next[2] = sb;
			s2_next[3] = db;
		end
	end

	always_ff @(posedge clk) begin
		s2_data_o <= s2_next;
	end

	always_ff @(posedge clk) begin
		s2_ctrl_o.radix <= s1_ctrl_i.radix;
		s2_ctrl_o.inverse <= s1_ctrl_i.inverse;
		s2_ctrl_o.shift <= s1_ctrl_i.shift;
		s2_ctrl_o.exp_next <= s1_ctrl_i.exp_next;
		if (!rst_n) begin
			s2_ctrl_o.valid <= 1'b0;
		end else begin
			s2_ctrl_o.valid <= s1_ctrl_i.valid;
		end
	end

endmodule

// ==== round_shift_lane.sv ====
`timescale 1ns/100ps

module round_shift_lane
	import fft_types_pkg::*;
	import radix_ctrl_pkg::*;
(
	input logic clk,
	input cplx2_t lane_i,
	input growth_t shift_i,
	output cplx_t lane_o
);

	// shift right, add the last bit shifted out, wrap to sample width
	function automatic sample_t round_shift(input s2_t v, input growth_t sh);
		s2_t pre;
		s2_t shifted;
		s2_t sum;
		logic rnd;
		if (sh == '0) begin
			shifted = v;
			rnd = 1'b0;
		end else begin
			// stop one bit short to catch the rounding bit
			pre = v >>> (sh - 2'd1);
			rnd = pre[0];
			shifted = pre >>> 1;
		end
		sum = shifted + s2_t'(rnd);
		return sample_t'(sum[sample_w-1:0]);
	endfunction

	always_ff @(posedge clk) begin
		lane_o.re <= round_shift(lane_i.re, shift_i);
		lane_o.im <= round_shift(lane_i.im, shift_i);
	end

endmodule

// ==== block_float_out.sv ====
`timescale 1ns/100ps

module block_float_out
	import radix_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input pipe_ctrl_t s2_ctrl_i,
	output logic out_val_o,
	output exp_t exp_o
);

	// valid lines up with the lane registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val_o <= 1'b0;
		end else begin
			out_val_o <= s2_ctrl_i.valid;
		end
	end

	// exponent only moves when a block completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_o <= '0;
		end else if (s2_ctrl_i.valid) begin
			exp_o <= s2_ctrl_i.exp_next;
		end
	end

endmodule

// ==== r24_butterfly.sv ====
`timescale 1ns/100ps

module r24_butterfly
	import fft_types_pkg::*;
	import radix_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_val_i,
	input blk_t din_i,
	input radix_sel_t radix_i,
	input logic inverse_i,
	input margin_t margin_i,
	input exp_t exp_i,
	output logic out_val_o,
	output wire blk_t dout_o,
	output exp_t exp_o
);

	blk1_t s1_data;
	pipe_ctrl_t s1_ctrl;
	blk2_t s2_data;
	pipe_ctrl_t s2_ctrl;

	// first layer and block scaling
	r24_input_stage u_input_stage (
		.clk(clk),
		.rst_n(rst_n),
		.in_val_i(in_val_i),
		.din_i(din_i),
		.radix_i(radix_i),
		.inverse_i(inverse_i),
		.margin_i(margin_i),
		.exp_i(exp_i),
		.s1_data_o(s1_data),
		.s1_ctrl_o(s1_ctrl)
	);

	// second layer
	r24_combine_stage u_combine_stage (
		.clk(clk),
		.rst_n(rst_n),
		.s1_data_i(s1_data),
		.s1_ctrl_i(s1_ctrl),
		.s2_data_o(s2_data),
		.s2_ctrl_o(s2_ctrl)
	);

	// one scaler per lane, all sharing the block shift
	for (genvar i = 0; i < n_lanes; i++) begin : g_lane
		round_shift_lane u_lane (
			.clk(clk),
			.lane_i(s2_data[i]),
			.shift_i(s2_ctrl.shift),
			.lane_o(dout_o[i])
		);
	end

	block_float_out u_block_float_out (
		.clk(clk),
		.rst_n(rst_n),
		.s2_ctrl_i(s2_ctrl),
		.out_val_o(out_val_o),
		.exp_o(exp_o)
	);

endmodule

// ==== r24_butterfly_tb.sv ====
`timescale 1ns/100ps

module r24_butterfly_tb
	import fft_types_pkg::*;
	import radix_ctrl_pkg::*;
();

	localparam int rand_seed = 17313;
	localparam int random_cycles = 400;
	localparam int burst_cycles = 200;
	localparam int extreme_cycles = 150;
	localparam int latency_timeout = 20;
	localparam int drain_timeout = 50;
	// cycles from an accepted block to its output
	localparam int pipe_latency = 3;

	// one expected result queued when the block enters
	typedef struct packed {
		blk_t data;
		exp_t expv;
		growth_t shift;
		radix_sel_t radix;
		logic inv;
		logic [31:0] due;
	} expect_t;

	logic clk;
	logic rst_n;
	logic in_val;
	blk_t din;
	radix_sel_t radix;
	logic inverse;
	margin_t margin;
	exp_t exp_in;
	logic out_val;
	blk_t dout;
	exp_t exp_out;

	expect_t pending[$];
	exp_t last_exp;
	int unsigned cyc;
	int data_errs;
	int exp_errs;
	int valid_errs;
	int other_errs;
	int blocks_seen;

	r24_butterfly u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_val_i(in_val),
		.din_i(din),
		.radix_i(radix),
		.inverse_i(inverse),
		.margin_i(margin),
		.exp_i(exp_in),
		.out_val_o(out_val),
		.dout_o(dout),
		.exp_o(exp_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// growth of the radix less the margin and floored at zero
	function automatic growth_t block_shift(input radix_sel_t r, input margin_t m);
		int g;
		int s;
		g = (r == radix_4) ? 3 : 2;
		s = g - int'(m);
		if (s < 0) begin
			s = 0;
		end
		return growth_t'(s);
	endfunction

	// divide by 2^sh with round half up and wrap to the sample width
	function automatic sample_t scale_round(input int v, input growth_t sh);
		int r;
		if (sh == 0) begin
			r = v;
		end else begin
			r = (v + (1 <<< (int'(sh) - 1))) >>> int'(sh);
		end
		return sample_t'(r);
	endfunction

	// one quarter turn of -j forward or +j inverse
	function automatic void quarter_turn(inout int re, inout int im, input logic inv);
		int t;
		t = re;
		if (!inv) begin
			re = im;
			im = -t;
		end else begin
			re = -im;
			im = t;
		end
	endfunction

	function automatic blk_t expected_block(input blk_t x, input radix_sel_t r,
		input logic inv, input growth_t sh);
		blk_t y;
		int xr[n_lanes];
		int xi[n_lanes];
		int acc_r;
		int acc_i;
		int tr;
		int ti;
		for (int n = 0; n < n_lanes; n++) begin
			xr[n] = x[n].re;
			xi[n] = x[n].im;
		end
		if (r == radix_4) begin
			// direct four-point DFT with twiddles as powers of the quarter turn
			for (int k = 0; k < n_lanes; k++) begin
				acc_r = 0;
				acc_i = 0;
				for (int n = 0; n < n_lanes; n++) begin
					tr = xr[n];
					ti = xi[n];
					repeat ((n * k) % 4) begin
						quarter_turn(tr, ti, inv);
					end
					acc_r += tr;
					acc_i += ti;
				end
				y[k].re = scale_round(acc_r, sh);
				y[k].im = scale_round(acc_i, sh);
			end
		end else begin
			// two independent two-point butterflies
			for (int p = 0; p < 2; p++) begin
				y[2*p].re = scale_round(xr[2*p] + xr[2*p+1], sh);
				y[2*p].im = scale_round(xi[2*p] + xi[2*p+1], sh);
				y[2*p+1].re = scale_round(xr[2*p] - xr[2*p+1], sh);
				y[2*p+1].im = scale_round(xi[2*p] - xi[2*p+1], sh);
			end
		end
		return y;
	endfunction

	task automatic check_block(input blk_t got, input blk_t want, input string what);
		for (int i = 0; i < n_lanes; i++) begin
			if (got[i] !== want[i]) begin
				data_errs++;
				$display("FAILED @%0t: lane %0d got %0d/%0d, expected %0d/%0d (%s)",
					$time, i, got[i].re, got[i].im, want[i].re, want[i].im, what);
			end
		end
	endtask

	task automatic check_exp(input exp_t got, input exp_t want, input string what);
		if (got !== want) begin
			exp_errs++;
			$display("FAILED @%0t: exponent %0d, expected %0d (%s)", $time, got, want, what);
		end
	endtask

	task automatic check_valid(input logic got, input logic want);
		if (got !== want) begin
			valid_errs++;
			$display("FAILED @%0t: out_val_o is %b, expected %b", $time, got, want);
		end
	endtask

	// model and scoreboard sample mid-cycle where everything is stable
	always @(negedge clk) begin : scoreboard
		expect_t e;
		logic want_val;
		string ctx;
		if (rst_n) begin
			cyc++;
			if (in_val === 1'b1) begin
				e.shift = block_shift(radix, margin);
				e.data = expected_block(din, radix, inverse, e.shift);
				e.expv = exp_t'(exp_in + exp_t'(e.shift));
				e.radix = radix;
				e.inv = inverse;
				e.due = cyc + pipe_latency;
				pending.push_back(e);
			end
			want_val = (pending.size() != 0) && (pending[0].due == cyc);
			check_valid(out_val, want_val);
			if (want_val) begin
				e = pending.pop_front();
				if (out_val === 1'b1) begin
					blocks_seen++;
					ctx = $sformatf("radix-%0d inv %0b shift %0d",
						e.radix ? 4 : 2, e.inv, e.shift);
					check_block(dout, e.data, ctx);
					check_exp(exp_out, e.expv, "new block");
					last_exp = e.expv;
				end
			end else if (out_val !== 1'b1) begin
				// exponent holds while no block completes
				check_exp(exp_out, last_exp, "idle hold");
			end
		end
	end

	function automatic sample_t random_sample(input logic extreme);
		int pick;
		if (!extreme) begin
			return sample_t'($urandom());
		end
		pick = $urandom_range(3, 0);
		case (pick)
			0: return {1'b0, {(sample_w-1){1'b1}}};
			1: return {1'b1, {(sample_w-1){1'b0}}};
			2: return {(sample_w){1'b1}};
			default: return sample_t'($urandom());
		endcase
	endfunction

	// one cycle of stimulus with valid set at the given chance in percent
	task automatic drive_cycle(input int valid_pct, input logic extreme);
		@(posedge clk);
		in_val <= ($urandom_range(99, 0) < valid_pct);
		radix <= radix_sel_t'($urandom_range(1, 0));
		inverse <= $urandom_range(1, 0);
		margin <= margin_t'($urandom_range(3, 0));
		exp_in <= exp_t'($urandom_range(15, 0));
		for (int i = 0; i < n_lanes; i++) begin
			din[i].re <= random_sample(extreme);
			din[i].im <= random_sample(extreme);
		end
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_val <= 1'b0;
		end
	endtask

	// count cycles until a lone block appears
	task automatic measure_latency();
		int lat;
		logic seen;
		drive_cycle(100, 1'b0);
		@(posedge clk);
		in_val <= 1'b0;
		lat = 1;
		seen = 1'b0;
		while (!seen && lat < latency_timeout) begin
			@(negedge clk);
			if (out_val === 1'b1) begin
				seen = 1'b1;
			end else begin
				lat++;
			end
		end
		if (!seen) begin
			other_errs++;
			$display("timeout: a single block never produced out_val_o");
		end else if (lat != pipe_latency) begin
			valid_errs++;
			$display("FAILED @%0t: block latency %0d cycles, expected %0d",
				$time, lat, pipe_latency);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < drain_timeout) begin
			@(posedge clk);
			in_val <= 1'b0;
			waited++;
		end
		if (pending.size() != 0) begin
			other_errs++;
			$display("timeout: %0d blocks still pending after %0d cycles",
				pending.size(), drain_timeout);
		end
	endtask

	initial begin
		void'($urandom(rand_seed));
		rst_n = 1'b0;
		in_val = 1'b0;
		din = '0;
		radix = radix_2;
		inverse = 1'b0;
		margin = '0;
		exp_in = '0;
		last_exp = '0;
		cyc = 0;
		data_errs = 0;
		exp_errs = 0;
		valid_errs = 0;
		other_errs = 0;
		blocks_seen = 0;

		repeat (5) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;

		// quiet after reset so the outputs stay at zero
		drive_idle(6);
		measure_latency();
		drive_idle(4);

		// sparse random blocks with idle gaps
		repeat (random_cycles) begin
			drive_cycle(50, 1'b0);
		end

		// back-to-back blocks of mixed radix
		repeat (burst_cycles) begin
			drive_cycle(100, 1'b0);
		end

		// full-scale samples to hit rounding and wrap
		repeat (extreme_cycles) begin
			drive_cycle(80, 1'b1);
		end

		drain_pipeline();
		drive_idle(8);
		@(negedge clk);

		if (blocks_seen == 0) begin
			other_errs++;
			$display("no block ever came out of the DUT");
		end

		$display("blocks %0d, errors: data %0d, exponent %0d, valid %0d, other %0d",
			blocks_seen, data_errs, exp_errs, valid_errs, other_errs);
		if (data_errs + exp_errs + valid_errs + other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== r24_butterfly.f ====
fft_types_pkg.sv
radix_ctrl_pkg.sv
r24_input_stage.sv
r24_combine_stage.sv
round_shift_lane.sv
block_float_out.sv
r24_butterfly.sv
r24_butterfly_tb.sv

// ==== Bender.yml ====
package:
  name: r24_butterfly

sources:
  - files:
      - fft_types_pkg.sv
      - radix_ctrl_pkg.sv
      - r24_input_stage.sv
      - r24_combine_stage.sv
      - round_shift_lane.sv
      - block_float_out.sv
      - r24_butterfly.sv
  - target: simulation
    files:
      - r24_butterfly_tb.sv
